// File: src/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int LINE_BYTES_MAX = 16;
    localparam int LINE_WIDTH     = LINE_BYTES_MAX * 8;

    typedef logic [ADDR_WIDTH-1:0] paddr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [LINE_WIDTH-1:0] line_t;

    // Access size encoding
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'b00;
    localparam size_t SIZE_HALF = 2'b01;
    localparam size_t SIZE_WORD = 2'b10;

    // One strobe per byte of a CPU word
    typedef logic [DATA_WIDTH/8-1:0] strb_t;

    // Accepted CPU request
    typedef struct packed {
        logic   wr;     // 1 = store
        paddr_t addr;   // Byte address
        data_t  wdata;  // Lane aligned store data
        size_t  size;
    } cpu_req_t;

    // Line-wide memory command
    typedef struct packed {
        logic   we;     // 1 = writeback
        paddr_t addr;   // Line aligned
        line_t  wdata;
    } mem_req_t;

endpackage

// File: src/dcache_lane.sv
`timescale 1ns/10ps

module dcache_lane import dcache_pkg::*; #(
    parameter int LINE_BYTES = LINE_BYTES_MAX
) (
    input  paddr_t lane_addr,
    input  size_t  lane_size,
    input  data_t  lane_wdata,
    input  line_t  line_in,
    output data_t  load_word,
    output line_t  merged_line
);

    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int WORD_W = $clog2(LINE_BYTES / 4);

    logic [WORD_W-1:0] word_off;
    logic [1:0]        byte_off;
    strb_t             strb;
    data_t             word_rd;
    data_t             word_sh;

    assign word_off = lane_addr[OFF_W-1:2];
    assign byte_off = lane_addr[1:0];

    assign word_rd = line_in[DATA_WIDTH*word_off +: DATA_WIDTH];
    assign word_sh = word_rd >> {byte_off, 3'b000};  // Addressed byte down to bit 0

    always_comb begin
        case (lane_size)
            SIZE_BYTE: strb = strb_t'(4'b0001) << byte_off;
            SIZE_HALF: strb = byte_off[1] ? strb_t'(4'b1100) : strb_t'(4'b0011);
            default:   strb = '1;
        endcase
    end

    always_comb begin
        case (lane_size)
            SIZE_BYTE: load_word = {24'h0, word_sh[7:0]};
            SIZE_HALF: load_word = {16'h0, word_sh[15:0]};
            default:   load_word = word_rd;
        endcase
    end

    // Store data sits in its byte lanes already
    always_comb begin
        merged_line = line_in;
        for (int b = 0; b < DATA_WIDTH / 8; b++) begin
            if (strb[b]) begin
                merged_line[DATA_WIDTH*word_off + 8*b +: 8] = lane_wdata[8*b +: 8];
            end
        end
    end

endmodule

// File: src/dcache_arrays.sv
`timescale 1ns/10ps

module dcache_arrays import dcache_pkg::*; #(
    parameter int N_LINES    = 8,
    parameter int LINE_BYTES = LINE_BYTES_MAX
) (
    input  logic   clk,
    input  logic   rstn,
    input  paddr_t look_addr,
    output logic   hit,
    output logic   victim_dirty,
    output paddr_t victim_tag_addr,
    output line_t  line_rd,
    input  logic   fill_en,
    input  logic   store_en,
    input  logic   inval_en,
    input  line_t  fill_line
);

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(N_LINES);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFF_W;

    logic [TAG_W-1:0]   tag_q [N_LINES];
    line_t              data_q [N_LINES];
    logic [N_LINES-1:0] valid_q;
    logic [N_LINES-1:0] dirty_q;

    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;

    assign idx = look_addr[OFF_W +: IDX_W];
    assign tag = look_addr[ADDR_WIDTH-1 -: TAG_W];

    assign hit             = valid_q[idx] && (tag_q[idx] == tag);
    assign victim_dirty    = valid_q[idx] && dirty_q[idx];
    assign victim_tag_addr = {tag_q[idx], idx, {OFF_W{1'b0}}};  // Line address of resident line
    assign line_rd         = data_q[idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_en) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= store_en;  // Store miss leaves the line dirty
            end else if (inval_en) begin
                valid_q[idx] <= 1'b0;
                dirty_q[idx] <= 1'b0;
            end else if (store_en) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[idx] <= tag;
        end
        if (fill_en || store_en) begin
            data_q[idx] <= fill_line;
        end
    end

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int N_LINES    = 8,
    parameter int LINE_BYTES = LINE_BYTES_MAX
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     cpu_req,
    input  cpu_req_t cpu_cmd,
    output logic     cpu_ready,
    output logic     cpu_rvalid,
    output data_t    cpu_rdata,
    output logic     mem_req,
    output mem_req_t mem_cmd,
    input  logic     mem_gnt,
    input  logic     mem_rvalid,
    input  line_t    mem_rdata,
    input  logic     flush,
    output logic     done,
    output paddr_t   look_addr,
    input  logic     hit,
    input  logic     victim_dirty,
    input  paddr_t   victim_tag_addr,
    input  line_t    line_rd,
    output logic     fill_en,
    output logic     store_en,
    output logic     inval_en,
    output line_t    fill_line,
    output paddr_t   lane_addr,
    output size_t    lane_size,
    output data_t    lane_wdata,
    output line_t    lane_line,
    input  data_t    load_word,
    input  line_t    merged_line
);

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(N_LINES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FLUSH_SCAN,
        ST_FLUSH_WB
    } state_t;

    state_t         state;
    cpu_req_t       pend;       // Request waiting on a miss
    mem_req_t       mem_cmd_q;
    logic           mem_req_q;
    logic [IDX_W:0] flush_idx;  // MSB set once every index is visited
    logic           rvalid_q;
    data_t          rdata_q;
    logic           in_idle;
    logic           accept;
    logic           miss;
    logic           flush_end;

    function automatic paddr_t line_base(input paddr_t a);
        return {a[ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};
    endfunction

    assign in_idle   = (state == ST_IDLE);
    assign cpu_ready = in_idle && !flush;  // Flush wins over a new request
    assign accept    = cpu_req && cpu_ready;
    assign miss      = accept && !hit;
    assign flush_end = flush_idx[IDX_W];

    assign cpu_rvalid = (accept && !cpu_cmd.wr && hit) || rvalid_q;
    assign cpu_rdata  = rvalid_q ? rdata_q : load_word;
    assign mem_req    = mem_req_q;
    assign mem_cmd    = mem_cmd_q;
    assign done       = (state == ST_FLUSH_SCAN) && flush_end;

    always_comb begin
        case (state)
            ST_IDLE:                    look_addr = cpu_cmd.addr;
            ST_FLUSH_SCAN, ST_FLUSH_WB: look_addr = paddr_t'({flush_idx[IDX_W-1:0], {OFF_W{1'b0}}});
            default:                    look_addr = pend.addr;
        endcase
    end

    // Store hit merges into the cached line, refill merges into the fetched one
    assign lane_addr  = in_idle ? cpu_cmd.addr : pend.addr;
    assign lane_size  = in_idle ? cpu_cmd.size : pend.size;
    assign lane_wdata = in_idle ? cpu_cmd.wdata : pend.wdata;
    assign lane_line  = in_idle ? line_rd : mem_rdata;

    assign fill_en   = (state == ST_REFILL) && mem_rvalid;
    assign store_en  = (accept && cpu_cmd.wr && hit) || (fill_en && pend.wr);
    assign fill_line = (in_idle || pend.wr) ? merged_line : mem_rdata;
    assign inval_en  = ((state == ST_FLUSH_SCAN) && !flush_end && !victim_dirty) ||
                       ((state == ST_FLUSH_WB) && mem_gnt);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            mem_req_q <= 1'b0;
            rvalid_q  <= 1'b0;
            flush_idx <= '0;
        end else begin
            rvalid_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (flush) begin
                        flush_idx <= '0;
                        state     <= ST_FLUSH_SCAN;
                    end else if (miss) begin
                        mem_req_q <= 1'b1;
                        state     <= victim_dirty ? ST_WRITEBACK : ST_REFILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (mem_gnt) begin
                        state <= ST_REFILL;  // mem_req stays up for the refill
                    end
                end
                ST_REFILL: begin
                    if (mem_gnt) begin
                        mem_req_q <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        rvalid_q <= !pend.wr;
                        state    <= ST_IDLE;
                    end
                end
                ST_FLUSH_SCAN: begin
                    if (flush_end) begin
                        state <= ST_IDLE;
                    end else if (victim_dirty) begin
                        mem_req_q <= 1'b1;
                        state     <= ST_FLUSH_WB;
                    end else begin
                        flush_idx <= flush_idx + 1'b1;
                    end
                end
                ST_FLUSH_WB: begin
                    if (mem_gnt) begin
                        mem_req_q <= 1'b0;
                        flush_idx <= flush_idx + 1'b1;
                        state     <= ST_FLUSH_SCAN;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_idle && miss) begin
            pend <= cpu_cmd;
            if (victim_dirty) begin
                mem_cmd_q <= '{we: 1'b1, addr: victim_tag_addr, wdata: line_rd};
            end else begin
                mem_cmd_q <= '{we: 1'b0, addr: line_base(cpu_cmd.addr), wdata: '0};
            end
        end
        if ((state == ST_WRITEBACK) && mem_gnt) begin
            mem_cmd_q <= '{we: 1'b0, addr: line_base(pend.addr), wdata: '0};
        end
        if ((state == ST_FLUSH_SCAN) && !flush_end && victim_dirty) begin
            mem_cmd_q <= '{we: 1'b1, addr: victim_tag_addr, wdata: line_rd};
        end
        if (fill_en) begin
            rdata_q <= load_word;
        end
    end

endmodule

// File: src/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; #(
    parameter int N_LINES    = 8,
    parameter int LINE_BYTES = LINE_BYTES_MAX
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     cpu_req,
    input  cpu_req_t cpu_cmd,
    output logic     cpu_ready,
    output logic     cpu_rvalid,
    output data_t    cpu_rdata,
    output logic     mem_req,
    output mem_req_t mem_cmd,
    input  logic     mem_gnt,
    input  logic     mem_rvalid,
    input  line_t    mem_rdata,
    input  logic     flush,
    output logic     done
);

    paddr_t look_addr;
    logic   hit;
    logic   victim_dirty;
    paddr_t victim_tag_addr;
    line_t  line_rd;
    logic   fill_en;
    logic   store_en;
    logic   inval_en;
    line_t  fill_line;
    paddr_t lane_addr;
    size_t  lane_size;
    data_t  lane_wdata;
    line_t  lane_line;
    data_t  load_word;
    line_t  merged_line;

    dcache_ctrl #(.N_LINES(N_LINES), .LINE_BYTES(LINE_BYTES)) u_ctrl (.*);

    dcache_arrays #(.N_LINES(N_LINES), .LINE_BYTES(LINE_BYTES)) u_arrays (.*);

    dcache_lane #(.LINE_BYTES(LINE_BYTES)) u_lane (
        .lane_addr   (lane_addr),
        .lane_size   (lane_size),
        .lane_wdata  (lane_wdata),
        .line_in     (lane_line),
        .load_word   (load_word),
        .merged_line (merged_line)
    );

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model import dcache_pkg::*; #(
    parameter int LINE_BYTES = LINE_BYTES_MAX
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     mem_req,
    input  mem_req_t mem_cmd,
    output logic     mem_gnt,
    output logic     mem_rvalid,
    output line_t    mem_rdata
);

    logic [7:0] backing [paddr_t];  // Only bytes written back so far
    int         seed = 32'h9dfe;
    int         gnt_wait;
    int         rd_wait;
    logic       rd_pend;
    paddr_t     rd_addr;

    function automatic logic [7:0] read_byte(input paddr_t a);
        return backing.exists(a) ? backing[a] : a[7:0] + 8'h5a;
    endfunction

    function automatic line_t read_line(input paddr_t a);
        line_t l;
        l = '0;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[8*i +: 8] = read_byte(a + i);
        end
        return l;
    endfunction

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_gnt    <= 1'b0;
            mem_rvalid <= 1'b0;
            mem_rdata  <= '0;
            gnt_wait   <= 0;
            rd_wait    <= 0;
            rd_pend    <= 1'b0;
            rd_addr    <= '0;
        end else begin
            mem_rvalid <= 1'b0;
            if (mem_gnt) begin
                mem_gnt  <= 1'b0;
                gnt_wait <= $unsigned($random(seed)) % 4;  // Delay of the next grant
                if (mem_cmd.we) begin
                    for (int i = 0; i < LINE_BYTES; i++) begin
                        backing[mem_cmd.addr + i] = mem_cmd.wdata[8*i +: 8];
                    end
                end else begin
                    rd_pend <= 1'b1;
                    rd_addr <= mem_cmd.addr;
                    rd_wait <= $unsigned($random(seed)) % 3;
                end
            end else if (mem_req && !rd_pend) begin
                if (gnt_wait == 0) begin
                    mem_gnt <= 1'b1;
                end else begin
                    gnt_wait <= gnt_wait - 1;
                end
            end
            if (rd_pend) begin
                if (rd_wait == 0) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= read_line(rd_addr);
                    rd_pend    <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache import dcache_pkg::*; ();

    localparam int PERIOD  = 8;
    localparam int TIMEOUT = 200;
    localparam int N_STEPS = 29;

    localparam logic [1:0] OP_LD    = 2'd0;
    localparam logic [1:0] OP_ST    = 2'd1;
    localparam logic [1:0] OP_FLUSH = 2'd2;
    localparam logic [1:0] OP_MEM   = 2'd3;  // Memory line against reference

    typedef struct packed {
        logic [1:0] op;
        paddr_t     addr;
        size_t      size;
        data_t      wdata;
        logic       hit;    // Access expected to hit
    } step_t;

    logic     clk;
    logic     rstn;
    logic     cpu_req;
    cpu_req_t cpu_cmd;
    logic     cpu_ready;
    logic     cpu_rvalid;
    data_t    cpu_rdata;
    logic     mem_req;
    mem_req_t mem_cmd;
    logic     mem_gnt;
    logic     mem_rvalid;
    line_t    mem_rdata;
    logic     flush;
    logic     done;

    logic [7:0] ref_mem [paddr_t];
    step_t      steps [N_STEPS];
    int         errors;

    dcache_top u_dut (.*);

    tb_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [7:0] ref_byte(input paddr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : a[7:0] + 8'h5a;
    endfunction

    // Byte lane b of the word is touched by an access of size s at a
    function automatic logic lane_on(input paddr_t a, input size_t s, input int b);
        case (s)
            SIZE_BYTE: return b == a[1:0];
            SIZE_HALF: return (b >> 1) == a[1];
            default:   return 1'b1;
        endcase
    endfunction

    task automatic ref_store(input paddr_t a, input size_t s, input data_t wd);
        for (int b = 0; b < 4; b++) begin
            if (lane_on(a, s, b)) begin
                ref_mem[{a[31:2], 2'b00} + b] = wd[8*b +: 8];
            end
        end
    endtask

    function automatic data_t ref_load(input paddr_t a, input size_t s);
        data_t w;
        int    n;
        w = '0;
        n = 0;
        for (int b = 0; b < 4; b++) begin
            if (lane_on(a, s, b)) begin
                w[8*n +: 8] = ref_byte({a[31:2], 2'b00} + b);
                n++;
            end
        end
        return w;
    endfunction

    function automatic line_t ref_line(input paddr_t a);
        line_t l;
        for (int i = 0; i < LINE_BYTES_MAX; i++) begin
            l[8*i +: 8] = ref_byte(a + i);
        end
        return l;
    endfunction

    function automatic string op_name(input logic [1:0] op);
        case (op)
            OP_LD:    return "load";
            OP_ST:    return "store";
            OP_FLUSH: return "flush";
            default:  return "memcheck";
        endcase
    endfunction

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %032h, expected %032h", $time, what, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s at %0t ns", TIMEOUT, what, $time);
        $display("ERRORS FOUND");
        $finish;
    endtask

    // Holds the request until taken, returns what the cache showed in that cycle
    task automatic issue(input cpu_req_t cmd, output logic rv_now, output data_t rd_now);
        int t;
        t = 0;
        @(posedge clk);
        cpu_req <= 1'b1;
        cpu_cmd <= cmd;
        @(negedge clk);
        while (!cpu_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!cpu_ready) begin
            stop_on_timeout("cpu_ready before accept");
        end
        rv_now = cpu_rvalid;
        rd_now = cpu_rdata;
        @(posedge clk);
        cpu_req <= 1'b0;
    endtask

    task automatic wait_for(input logic want_rvalid, output data_t rd);
        int t;
        t = 0;
        @(negedge clk);
        while (!(want_rvalid ? cpu_rvalid : cpu_ready) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!(want_rvalid ? cpu_rvalid : cpu_ready)) begin
            stop_on_timeout(want_rvalid ? "cpu_rvalid" : "cpu_ready");
        end
        rd = cpu_rdata;
    endtask

    task automatic run_step(input step_t s);
        cpu_req_t cmd;
        logic     rv_now;
        data_t    rd;
        int       pulses;
        int       t;
        cmd.wr    = (s.op == OP_ST);
        cmd.addr  = s.addr;
        cmd.wdata = s.wdata;
        cmd.size  = s.size;
        case (s.op)
            OP_LD: begin
                issue(cmd, rv_now, rd);
                check_bit("load hit", rv_now, s.hit);
                if (!rv_now) begin
                    wait_for(1'b1, rd);
                end
                check_word("load data", rd, ref_load(s.addr, s.size));
            end
            OP_ST: begin
                issue(cmd, rv_now, rd);
                check_bit("store rvalid", rv_now, 1'b0);
                ref_store(s.addr, s.size, s.wdata);
                @(negedge clk);
                check_bit("store hit", cpu_ready, s.hit);  // A miss drops ready
                wait_for(1'b0, rd);  // Store miss ends when ready returns
            end
            OP_FLUSH: begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                pulses = 0;
                t = 0;
                @(negedge clk);
                while (!cpu_ready && t < TIMEOUT) begin
                    pulses += done;
                    @(negedge clk);
                    t++;
                end
                if (!cpu_ready) begin
                    stop_on_timeout("end of flush");
                end
                check_word("done pulses", data_t'(pulses), data_t'(1));
            end
            default: begin
                check_line("memory line", u_mem.read_line(s.addr), ref_line(s.addr));
            end
        endcase
    endtask

    initial begin
        int errs_before;
        rstn    = 1'b0;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        flush   = 1'b0;
        errors  = 0;
        // Index 0 lines 0x1000 and 0x1080 collide, 0x1010 and 0x1120 sit at 1 and 2
        steps = '{
            {OP_LD,    32'h0000_1000, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_LD,    32'h0000_1004, SIZE_WORD, 32'h0000_0000, 1'b1},
            {OP_LD,    32'h0000_100d, SIZE_BYTE, 32'h0000_0000, 1'b1},
            {OP_ST,    32'h0000_1000, SIZE_BYTE, 32'h1122_3344, 1'b1},
            {OP_ST,    32'h0000_1001, SIZE_BYTE, 32'h5566_7788, 1'b1},
            {OP_ST,    32'h0000_1002, SIZE_BYTE, 32'h99aa_bbcc, 1'b1},
            {OP_ST,    32'h0000_1003, SIZE_BYTE, 32'hddee_ff01, 1'b1},
            {OP_ST,    32'h0000_1004, SIZE_HALF, 32'h1234_5678, 1'b1},
            {OP_ST,    32'h0000_1006, SIZE_HALF, 32'h9abc_def0, 1'b1},
            {OP_ST,    32'h0000_1008, SIZE_WORD, 32'hcafe_f00d, 1'b1},
            {OP_LD,    32'h0000_1000, SIZE_WORD, 32'h0000_0000, 1'b1},
            {OP_LD,    32'h0000_1004, SIZE_WORD, 32'h0000_0000, 1'b1},
            {OP_LD,    32'h0000_1008, SIZE_WORD, 32'h0000_0000, 1'b1},
            {OP_LD,    32'h0000_1006, SIZE_BYTE, 32'h0000_0000, 1'b1},
            {OP_LD,    32'h0000_100a, SIZE_HALF, 32'h0000_0000, 1'b1},
            {OP_LD,    32'h0000_1080, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_MEM,   32'h0000_1000, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_ST,    32'h0000_1086, SIZE_BYTE, 32'h00a5_0000, 1'b1},
            {OP_ST,    32'h0000_1010, SIZE_WORD, 32'h0bad_beef, 1'b0},
            {OP_ST,    32'h0000_1122, SIZE_HALF, 32'h7e57_0000, 1'b0},
            {OP_LD,    32'h0000_1122, SIZE_HALF, 32'h0000_0000, 1'b1},
            {OP_FLUSH, 32'h0000_0000, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_MEM,   32'h0000_1080, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_MEM,   32'h0000_1010, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_MEM,   32'h0000_1120, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_LD,    32'h0000_1010, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_LD,    32'h0000_1084, SIZE_WORD, 32'h0000_0000, 1'b0},
            {OP_LD,    32'h0000_1123, SIZE_BYTE, 32'h0000_0000, 1'b0},
            {OP_LD,    32'h0000_1000, SIZE_WORD, 32'h0000_0000, 1'b0}
        };
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_bit("cpu_ready after reset", cpu_ready, 1'b1);
        check_bit("cpu_rvalid after reset", cpu_rvalid, 1'b0);
        check_bit("done after reset", done, 1'b0);
        check_bit("mem_req after reset", mem_req, 1'b0);
        $display("test reset: %s", (errors == 0) ? "pass" : "fail");
        for (int i = 0; i < N_STEPS; i++) begin
            errs_before = errors;
            run_step(steps[i]);
            $display("test %0d %s 0x%08h: %s", i, op_name(steps[i].op), steps[i].addr,
                     (errors == errs_before) ? "pass" : "fail");
        end
        $display("%0d tests run, %0d errors", N_STEPS + 1, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/dcache_pkg.sv
src/dcache_lane.sv
src/dcache_arrays.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - src/dcache_pkg.sv
      - src/dcache_lane.sv
      - src/dcache_arrays.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_dcache.sv
